//--- be_arbiter.sv
`include "cache_macros.svh"

module be_arbiter
   import cache_pkg::*;
(
   input  logic       clk_i,
   input  logic       rst_i,
   input  logic       c0_req_i,
   input  word_addr_t c0_addr_i,
   input  data_t      c0_wdata_i,
   input  wstrb_t     c0_wstrb_i,
   output data_t      c0_rdata_o,
   output logic       c0_ack_o,
   input  logic       c1_req_i,
   input  word_addr_t c1_addr_i,
   input  data_t      c1_wdata_i,
   input  wstrb_t     c1_wstrb_i,
   output data_t      c1_rdata_o,
   output logic       c1_ack_o,
   output logic       ram_en_o,
   output word_addr_t ram_addr_o,
   output data_t      ram_wdata_o,
   output wstrb_t     ram_wstrb_o,
   input  data_t      ram_rdata_i,
   input  logic       ram_ack_i
);

   arb_owner_t owner_q;
   arb_owner_t owner_d;
   logic       last_c1_q;      // Set when client 1 had the last grant.
   logic       ram_en_q;
   logic       free;
   logic       grant;
   logic       c0_cand;
   logic       c1_cand;

   // The bus is free with no owner, or in the owner's ack cycle. The owner's
   // request is still high then and must not win again.
   assign free    = (owner_q == NONE) || ram_ack_i;
   assign c0_cand = c0_req_i && !(ram_ack_i && owner_q == CLIENT0);
   assign c1_cand = c1_req_i && !(ram_ack_i && owner_q == CLIENT1);

   always_comb begin
      owner_d = owner_q;
      if (free) begin
         if (c0_cand && c1_cand) begin
            owner_d = last_c1_q ? CLIENT0 : CLIENT1;
         end else if (c0_cand) begin
            owner_d = CLIENT0;
         end else if (c1_cand) begin
            owner_d = CLIENT1;
         end else begin
            owner_d = NONE;
         end
      end
   end

   assign grant = free && (owner_d != NONE);

   always_ff @(posedge clk_i or posedge rst_i) begin
      if (rst_i) begin
         owner_q   <= NONE;
         last_c1_q <= 1'b1;                     // First tie goes to client 0.
         ram_en_q  <= 1'b0;
      end else begin
         owner_q  <= owner_d;
         ram_en_q <= grant;                     // One enable per grant.
         if (grant) begin
            last_c1_q <= (owner_d == CLIENT1);
         end
      end
   end

   assign ram_en_o    = ram_en_q;
   assign ram_addr_o  = (owner_q == CLIENT1) ? c1_addr_i : c0_addr_i;
   assign ram_wdata_o = (owner_q == CLIENT1) ? c1_wdata_i : c0_wdata_i;
   assign ram_wstrb_o = (owner_q == CLIENT1) ? c1_wstrb_i : c0_wstrb_i;

   assign c0_ack_o   = ram_ack_i && (owner_q == CLIENT0);
   assign c1_ack_o   = ram_ack_i && (owner_q == CLIENT1);
   assign c0_rdata_o = (owner_q == CLIENT0) ? ram_rdata_i : '0;
   assign c1_rdata_o = (owner_q == CLIENT1) ? ram_rdata_i : '0;

endmodule

//--- be_ram.sv
`include "cache_macros.svh"

module be_ram
   import cache_pkg::*;
(
   input  logic       clk_i,
   input  logic       rst_i,
   input  logic       en_i,
   input  word_addr_t addr_i,
   input  data_t      wdata_i,
   input  wstrb_t     wstrb_i,
   output data_t      rdata_o,
   output logic       ack_o
);

   data_t mem [`CACHE_RAM_DEPTH] = '{default: '0};

   // Read returns the word as it was before a write in the same cycle.
   always_ff @(posedge clk_i) begin
      if (en_i) begin
         for (int b = 0; b < `CACHE_NBYTES; b++) begin
            if (wstrb_i[b]) begin
               mem[addr_i][8*b +: 8] <= wdata_i[8*b +: 8];
            end
         end
         rdata_o <= mem[addr_i];
      end
   end

   always_ff @(posedge clk_i or posedge rst_i) begin
      if (rst_i) begin
         ack_o <= 1'b0;
      end else begin
         ack_o <= en_i;
      end
   end

endmodule

//--- cache_dm.sv
`include "cache_macros.svh"

module cache_dm
   import cache_pkg::*;
(
   input  logic       clk_i,
   input  logic       rst_i,
   input  logic       invalidate_i,
   input  logic       req_i,
   input  word_addr_t addr_i,
   input  data_t      wdata_i,
   input  wstrb_t     wstrb_i,
   output data_t      rdata_o,
   output logic       ack_o,
   output logic       be_req_o,
   output word_addr_t be_addr_o,
   output data_t      be_wdata_o,
   output wstrb_t     be_wstrb_o,
   input  data_t      be_rdata_i,
   input  logic       be_ack_i
);

   localparam int NLINES = 1 << `CACHE_INDEX_W;

   cache_state_t state_q;
   cache_state_t state_d;
   logic         ack_q;        // Ack of a fill or a write, one cycle after be_ack.

   logic [NLINES-1:0] valid_q;
   line_tag_t         tag_mem [NLINES];
   data_t             data_mem [NLINES];

   line_index_t idx;
   line_tag_t   tag;
   logic        hit;
   logic        is_write;

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Lookup. The master holds addr_i stable for the whole request.
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   assign idx      = addr_i[`CACHE_INDEX_W-1:0];
   assign tag      = addr_i[`CACHE_ADDR_W-1:`CACHE_INDEX_W];
   assign is_write = |wstrb_i;
   assign hit      = valid_q[idx] && (tag_mem[idx] == tag);

   always_comb begin
      state_d = state_q;
      case (state_q)
         IDLE: begin
            // The request that was just acknowledged is still up for one cycle.
            if (req_i && !ack_q) begin
               state_d = LOOKUP;
            end
         end
         LOOKUP: begin
            if (is_write) begin
               state_d = WRITE;
            end else if (!hit) begin
               state_d = FILL;
            end else begin
               state_d = IDLE;                  // Read hit, acknowledged now.
            end
         end
         FILL, WRITE: begin
            if (be_ack_i) begin
               state_d = IDLE;
            end
         end
         default: state_d = IDLE;
      endcase
   end

   always_ff @(posedge clk_i or posedge rst_i) begin
      if (rst_i) begin
         state_q <= IDLE;
         ack_q   <= 1'b0;
      end else begin
         state_q <= state_d;
         ack_q   <= be_req_o && be_ack_i;
      end
   end

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Line storage.
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   always_ff @(posedge clk_i or posedge rst_i) begin
      if (rst_i) begin
         valid_q <= '0;
      end else if (invalidate_i) begin
         valid_q <= '0;                         // Only legal while the port is idle.
      end else if (state_q == FILL && be_ack_i) begin
         valid_q[idx] <= 1'b1;
      end
   end

   always_ff @(posedge clk_i) begin
      if (state_q == FILL && be_ack_i) begin
         tag_mem[idx]  <= tag;
         data_mem[idx] <= be_rdata_i;
      end else if (state_q == WRITE && be_ack_i && hit) begin
         // Write-through hit, keep the line in step with the RAM.
         for (int b = 0; b < `CACHE_NBYTES; b++) begin
            if (wstrb_i[b]) begin
               data_mem[idx][8*b +: 8] <= wdata_i[8*b +: 8];
            end
         end
      end
   end

   // After a fill the line already holds the returned word.
   assign rdata_o = data_mem[idx];
   assign ack_o   = ack_q || (state_q == LOOKUP && !is_write && hit);

   assign be_req_o   = (state_q == FILL) || (state_q == WRITE);
   assign be_addr_o  = addr_i;
   assign be_wdata_o = wdata_i;
   assign be_wstrb_o = (state_q == WRITE) ? wstrb_i : '0;

endmodule

//--- cache_macros.svh
`ifndef CACHE_MACROS_SVH
`define CACHE_MACROS_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Widths shared by both caches, the arbiter and the backing RAM.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`define CACHE_ADDR_W    10                    // Word address, not byte address.
`define CACHE_DATA_W    32
`define CACHE_NBYTES    4                     // One strobe per data byte.

// Sixteen one-word lines per cache.
`define CACHE_INDEX_W   4
`define CACHE_TAG_W     (`CACHE_ADDR_W - `CACHE_INDEX_W)

// The RAM covers the whole word address space.
`define CACHE_RAM_DEPTH (1 << `CACHE_ADDR_W)

`endif

//--- cache_pair_top.sv
`include "cache_macros.svh"

module cache_pair_top
   import cache_pkg::*;
(
   input  logic       clk_i,
   input  logic       rst_i,
   input  logic       invalidate_i,
   input  logic       p0_req_i,
   input  word_addr_t p0_addr_i,
   input  data_t      p0_wdata_i,
   input  wstrb_t     p0_wstrb_i,
   output data_t      p0_rdata_o,
   output logic       p0_ack_o,
   input  logic       p1_req_i,
   input  word_addr_t p1_addr_i,
   input  data_t      p1_wdata_i,
   input  wstrb_t     p1_wstrb_i,
   output data_t      p1_rdata_o,
   output logic       p1_ack_o
);

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Back-end wires, one set per cache and one to the RAM.
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   logic       c0_req;
   word_addr_t c0_addr;
   data_t      c0_wdata;
   wstrb_t     c0_wstrb;
   data_t      c0_rdata;
   logic       c0_ack;

   logic       c1_req;
   word_addr_t c1_addr;
   data_t      c1_wdata;
   wstrb_t     c1_wstrb;
   data_t      c1_rdata;
   logic       c1_ack;

   logic       ram_en;
   word_addr_t ram_addr;
   data_t      ram_wdata;
   wstrb_t     ram_wstrb;
   data_t      ram_rdata;
   logic       ram_ack;

   // Both caches take the same invalidate pulse.
   cache_dm i_cache0 (
      .clk_i        (clk_i),
      .rst_i        (rst_i),
      .invalidate_i (invalidate_i),
      .req_i        (p0_req_i),
      .addr_i       (p0_addr_i),
      .wdata_i      (p0_wdata_i),
      .wstrb_i      (p0_wstrb_i),
      .rdata_o      (p0_rdata_o),
      .ack_o        (p0_ack_o),
      .be_req_o     (c0_req),
      .be_addr_o    (c0_addr),
      .be_wdata_o   (c0_wdata),
      .be_wstrb_o   (c0_wstrb),
      .be_rdata_i   (c0_rdata),
      .be_ack_i     (c0_ack)
   );

   cache_dm i_cache1 (
      .clk_i        (clk_i),
      .rst_i        (rst_i),
      .invalidate_i (invalidate_i),
      .req_i        (p1_req_i),
      .addr_i       (p1_addr_i),
      .wdata_i      (p1_wdata_i),
      .wstrb_i      (p1_wstrb_i),
      .rdata_o      (p1_rdata_o),
      .ack_o        (p1_ack_o),
      .be_req_o     (c1_req),
      .be_addr_o    (c1_addr),
      .be_wdata_o   (c1_wdata),
      .be_wstrb_o   (c1_wstrb),
      .be_rdata_i   (c1_rdata),
      .be_ack_i     (c1_ack)
   );

   be_arbiter i_be_arbiter (
      .clk_i       (clk_i),
      .rst_i       (rst_i),
      .c0_req_i    (c0_req),
      .c0_addr_i   (c0_addr),
      .c0_wdata_i  (c0_wdata),
      .c0_wstrb_i  (c0_wstrb),
      .c0_rdata_o  (c0_rdata),
      .c0_ack_o    (c0_ack),
      .c1_req_i    (c1_req),
      .c1_addr_i   (c1_addr),
      .c1_wdata_i  (c1_wdata),
      .c1_wstrb_i  (c1_wstrb),
      .c1_rdata_o  (c1_rdata),
      .c1_ack_o    (c1_ack),
      .ram_en_o    (ram_en),
      .ram_addr_o  (ram_addr),
      .ram_wdata_o (ram_wdata),
      .ram_wstrb_o (ram_wstrb),
      .ram_rdata_i (ram_rdata),
      .ram_ack_i   (ram_ack)
   );

   be_ram i_be_ram (
      .clk_i   (clk_i),
      .rst_i   (rst_i),
      .en_i    (ram_en),
      .addr_i  (ram_addr),
      .wdata_i (ram_wdata),
      .wstrb_i (ram_wstrb),
      .rdata_o (ram_rdata),
      .ack_o   (ram_ack)
   );

endmodule

//--- cache_pkg.sv
`include "cache_macros.svh"

package cache_pkg;

   typedef logic [`CACHE_ADDR_W-1:0]  word_addr_t;
   typedef logic [`CACHE_DATA_W-1:0]  data_t;
   typedef logic [`CACHE_NBYTES-1:0]  wstrb_t;      // All zero means a read.

   // A word address splits into tag (high bits) and line index (low bits).
   typedef logic [`CACHE_INDEX_W-1:0] line_index_t;
   typedef logic [`CACHE_TAG_W-1:0]   line_tag_t;

   typedef enum logic [1:0] {
      IDLE,
      LOOKUP,
      FILL,
      WRITE
   } cache_state_t;

   typedef enum logic [1:0] {
      NONE,
      CLIENT0,
      CLIENT1
   } arb_owner_t;

endpackage

//--- filelist.f
+incdir+.
cache_pkg.sv
cache_dm.sv
be_arbiter.sv
be_ram.sv
cache_pair_top.sv
tb_cache_pair.sv

//--- run_sim.sh
#!/bin/sh
# Builds the cache pair testbench with Verilator, runs it and checks the log.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

if ! verilator --binary --timescale 1ns/1ps --top-module tb_cache_pair \
      -f filelist.f -o sim_cache_pair; then
   echo "Verilator build failed."
   exit 1
fi

if ! ./obj_dir/sim_cache_pair > "$LOG" 2>&1; then
   cat "$LOG"
   echo "Simulation run ended with an error status."
   exit 1
fi

cat "$LOG"

if grep -q "Simulation PASSED" "$LOG"; then
   exit 0
else
   echo "Pass message not found in $LOG."
   exit 1
fi

//--- tb_cache_pair.sv
`include "cache_macros.svh"

module tb_cache_pair
   import cache_pkg::*;
();

   timeunit 1ns;
   timeprecision 1ps;

   typedef struct {
      int         port;        // 0 or 1, or 2 for an invalidate pulse.
      logic       pair;        // Starts in the same cycle as the next entry.
      word_addr_t addr;
      data_t      wdata;
      wstrb_t     wstrb;
      data_t      exp_rdata;
      logic       exp_hit;
   } entry_t;

   logic       clk;
   logic       rst;
   logic       invalidate;
   logic       p0_req;
   word_addr_t p0_addr;
   data_t      p0_wdata;
   wstrb_t     p0_wstrb;
   data_t      p0_rdata;
   logic       p0_ack;
   logic       p1_req;
   word_addr_t p1_addr;
   data_t      p1_wdata;
   wstrb_t     p1_wstrb;
   data_t      p1_rdata;
   logic       p1_ack;

   entry_t     tbl [$];
   int         seed = 32'h81c1_ea64;

   // Model of the backing memory and of one line array per port.
   data_t      mem_model [1 << `CACHE_ADDR_W];
   logic       line_valid [2][1 << `CACHE_INDEX_W];
   line_tag_t  line_tag [2][1 << `CACHE_INDEX_W];
   data_t      line_word [2][1 << `CACHE_INDEX_W];

   cache_pair_top i_cache_pair_top (
      .clk_i        (clk),
      .rst_i        (rst),
      .invalidate_i (invalidate),
      .p0_req_i     (p0_req),
      .p0_addr_i    (p0_addr),
      .p0_wdata_i   (p0_wdata),
      .p0_wstrb_i   (p0_wstrb),
      .p0_rdata_o   (p0_rdata),
      .p0_ack_o     (p0_ack),
      .p1_req_i     (p1_req),
      .p1_addr_i    (p1_addr),
      .p1_wdata_i   (p1_wdata),
      .p1_wstrb_i   (p1_wstrb),
      .p1_rdata_o   (p1_rdata),
      .p1_ack_o     (p1_ack)
   );

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Checking and DUT access.
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   task automatic check_value(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
      if (actual !== expected) begin
         $display("CHECK FAILED at %0d ns: %s is %h, expected %h",
                  $time, name, actual, expected);
         $display("Simulation FAILED");
         $fatal(1, "Stopped at the first mismatch.");
      end
   endtask

   function automatic logic ack_of(input int p);
      return (p == 0) ? p0_ack : p1_ack;
   endfunction

   function automatic data_t rdata_of(input int p);
      return (p == 0) ? p0_rdata : p1_rdata;
   endfunction

   task automatic drive_port(input int p, input logic req, input word_addr_t a,
                             input data_t d, input wstrb_t s);
      if (p == 0) begin
         p0_req   = req;
         p0_addr  = a;
         p0_wdata = d;
         p0_wstrb = s;
      end else begin
         p1_req   = req;
         p1_addr  = a;
         p1_wdata = d;
         p1_wstrb = s;
      end
   endtask

   function automatic data_t merge_bytes(input data_t old_word, input data_t new_word,
                                         input wstrb_t strb);
      data_t w;
      w = old_word;
      for (int b = 0; b < `CACHE_NBYTES; b++) begin
         if (strb[b]) begin
            w[8*b +: 8] = new_word[8*b +: 8];
         end
      end
      return w;
   endfunction

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Table construction. Expected values follow the write-through,
   // no-write-allocate rules, in table order.
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   task automatic add_entry(input int port, input logic pair, input word_addr_t a,
                            input data_t d, input wstrb_t s);
      entry_t      e;
      line_index_t idx;
      line_tag_t   tg;
      logic        hit;
      idx = a[`CACHE_INDEX_W-1:0];
      tg  = a[`CACHE_ADDR_W-1:`CACHE_INDEX_W];
      e.port      = port;
      e.pair      = pair;
      e.addr      = a;
      e.wdata     = d;
      e.wstrb     = s;
      e.exp_rdata = '0;
      e.exp_hit   = 1'b0;
      if (port == 2) begin
         for (int i = 0; i < (1 << `CACHE_INDEX_W); i++) begin
            line_valid[0][i] = 1'b0;
            line_valid[1][i] = 1'b0;
         end
      end else begin
         hit       = line_valid[port][idx] && (line_tag[port][idx] == tg);
         e.exp_hit = hit;
         if (s == '0) begin
            e.exp_rdata = hit ? line_word[port][idx] : mem_model[a];
            if (!hit) begin
               line_valid[port][idx] = 1'b1;      // A read miss allocates.
               line_tag[port][idx]   = tg;
               line_word[port][idx]  = mem_model[a];
            end
         end else begin
            mem_model[a] = merge_bytes(mem_model[a], d, s);
            if (hit) begin
               line_word[port][idx] = merge_bytes(line_word[port][idx], d, s);
            end
         end
      end
      tbl.push_back(e);
   endtask

   task automatic build_table();
      logic [31:0] r;
      for (int i = 0; i < (1 << `CACHE_ADDR_W); i++) begin
         mem_model[i] = '0;
      end
      add_entry(2, 1'b0, '0, '0, '0);
      add_entry(0, 1'b0, 10'h005, '0, 4'b0000);            // Miss on zero memory.
      add_entry(0, 1'b0, 10'h005, '0, 4'b0000);
      add_entry(0, 1'b0, 10'h021, 32'hdead_beef, 4'b1111);
      add_entry(0, 1'b0, 10'h021, '0, 4'b0000);
      add_entry(0, 1'b0, 10'h021, 32'h1234_5678, 4'b0101); // Partial write hit.
      add_entry(0, 1'b0, 10'h021, '0, 4'b0000);
      // Index 3 with two tags.
      add_entry(1, 1'b0, 10'h013, 32'h1111_1111, 4'b1111);
      add_entry(1, 1'b0, 10'h033, 32'h2222_2222, 4'b1111);
      add_entry(0, 1'b0, 10'h013, '0, 4'b0000);
      add_entry(0, 1'b0, 10'h033, '0, 4'b0000);
      add_entry(0, 1'b0, 10'h013, '0, 4'b0000);
      // Stale line in port 0 until the invalidate.
      add_entry(1, 1'b0, 10'h021, 32'hcafe_f00d, 4'b1111);
      add_entry(0, 1'b0, 10'h021, '0, 4'b0000);
      add_entry(2, 1'b0, '0, '0, '0);
      add_entry(0, 1'b0, 10'h021, '0, 4'b0000);
      add_entry(0, 1'b1, 10'h100, 32'h0bad_cafe, 4'b1111);
      add_entry(1, 1'b0, 10'h033, '0, 4'b0000);
      add_entry(0, 1'b1, 10'h100, '0, 4'b0000);
      add_entry(1, 1'b0, 10'h021, '0, 4'b0000);
      for (int n = 0; n < 40; n++) begin
         r = $random(seed);
         if (n == 20) begin
            add_entry(2, 1'b0, '0, '0, '0);
         end
         add_entry(r[0] ? 1 : 0, 1'b0, word_addr_t'(r[13:8]), $random(seed),
                   r[1] ? r[7:4] : 4'b0000);
      end
   endtask

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Table replay.
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   task automatic pulse_invalidate();
      @(negedge clk);
      invalidate = 1'b1;
      @(negedge clk);
      invalidate = 1'b0;
   endtask

   task automatic run_requests(input int first, input int count);
      int   slot [2];
      logic busy [2];
      int   cycles;
      int   k;
      int   p;
      busy[0] = 1'b0;
      busy[1] = 1'b0;
      @(negedge clk);                             // One idle cycle between requests.
      for (k = first; k < first + count; k++) begin
         p       = tbl[k].port;
         slot[p] = k;
         busy[p] = 1'b1;
         drive_port(p, 1'b1, tbl[k].addr, tbl[k].wdata, tbl[k].wstrb);
      end
      cycles = 0;
      while (busy[0] || busy[1]) begin
         if (cycles == 50) begin
            for (p = 0; p < 2; p++) begin
               if (busy[p]) begin
                  $display("Timeout: port %0d never acknowledged its request.", p);
               end
            end
            $display("Simulation FAILED");
            $fatal(1, "Request timed out.");
         end
         @(negedge clk);
         cycles++;
         for (p = 0; p < 2; p++) begin
            if (busy[p] && ack_of(p)) begin
               busy[p] = 1'b0;
               k       = slot[p];
               // Payload stays put through the ack cycle.
               drive_port(p, 1'b0, tbl[k].addr, tbl[k].wdata, tbl[k].wstrb);
               if (tbl[k].wstrb == '0) begin
                  check_value($sformatf("p%0d_rdata_o", p), rdata_of(p), tbl[k].exp_rdata);
                  check_value($sformatf("p%0d hit latency", p), 32'(cycles == 1),
                              32'(tbl[k].exp_hit));
               end
            end
         end
      end
   endtask

   initial begin
      int i;
      int count;
      rst        = 1'b1;
      invalidate = 1'b0;
      drive_port(0, 1'b0, '0, '0, '0);
      drive_port(1, 1'b0, '0, '0, '0);
      build_table();
      repeat (10) @(negedge clk);
      rst = 1'b0;
      i = 0;
      while (i < tbl.size()) begin
         count = tbl[i].pair ? 2 : 1;
         if (tbl[i].port == 2) begin
            pulse_invalidate();
         end else begin
            run_requests(i, count);
         end
         i += count;
      end
      $display("Simulation PASSED");
      $finish;
   end

endmodule
